//--- common/opl_ops_pkg.sv
`default_nettype none

package opl_ops_pkg;

    localparam int NUM_OPERATORS = 18;     // operator slots per sample
    localparam int NUM_CHANNELS = 9;       // two operators each
    localparam int SLOT_CYCLES = 2;        // modulator result ready for its carrier
    localparam int PIPELINE_DELAY = 6;     // issue to result

    localparam int OP_NUM_WIDTH = 5;
    localparam int CHAN_WIDTH = 4;
    localparam int REG_ADDR_WIDTH = 8;
    localparam int REG_DATA_WIDTH = 8;

    localparam int FNUM_WIDTH = 10;
    localparam int BLOCK_WIDTH = 3;
    localparam int MULT_WIDTH = 4;
    localparam int TL_WIDTH = 6;

    localparam int PHASE_WIDTH = 20;       // accumulator
    localparam int PHASE_INDEX_WIDTH = 10; // top bits used as wave index
    localparam int OP_OUT_WIDTH = 13;

    typedef struct packed {
        logic                      valid;
        logic [REG_ADDR_WIDTH-1:0] address;
        logic [REG_DATA_WIDTH-1:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic                    valid;
        logic [OP_NUM_WIDTH-1:0] op_num;
    } op_tag_t;

    typedef struct packed {
        logic [MULT_WIDTH-1:0]  mult;
        logic [TL_WIDTH-1:0]    tl;
        logic [FNUM_WIDTH-1:0]  fnum;
        logic [BLOCK_WIDTH-1:0] block;
        logic                   kon;
        logic                   cnt;   // 1 = additive
    } op_params_t;

    typedef struct packed {
        logic                           valid;
        logic [OP_NUM_WIDTH-1:0]        op_num;
        logic signed [OP_OUT_WIDTH-1:0] op_out;
    } operator_out_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_WAIT
    } seq_state_t;

    // ops n and n+3 of each group of six share a channel
    function automatic logic [CHAN_WIDTH-1:0] op_channel(input logic [OP_NUM_WIDTH-1:0] op_num);
        int group;
        int pos;
        group = int'(op_num) / 6;
        pos = int'(op_num) % 6;
        return CHAN_WIDTH'(group * 3 + pos % 3);
    endfunction

    function automatic logic op_is_carrier(input logic [OP_NUM_WIDTH-1:0] op_num);
        return (int'(op_num) % 6) >= 3;
    endfunction

    // register offset of an operator, two-entry gap after every six
    function automatic logic [OP_NUM_WIDTH-1:0] op_slot_addr(input logic [OP_NUM_WIDTH-1:0] op_num);
        if (op_num < 6)
            return op_num;
        else if (op_num < 12)
            return op_num + OP_NUM_WIDTH'(2);
        else
            return op_num + OP_NUM_WIDTH'(4);
    endfunction

endpackage

`default_nettype wire

//--- source/slot_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module slot_sequencer #(
    parameter int NUM_OPERATORS = opl_ops_pkg::NUM_OPERATORS,
    parameter int SLOT_CYCLES = opl_ops_pkg::SLOT_CYCLES
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        sample_clk_en,
    input  opl_ops_pkg::operator_out_t  operator_out,
    output opl_ops_pkg::op_tag_t        issue,
    output logic                        ops_done_pulse
);
    import opl_ops_pkg::*;

    // SLOT_CYCLES must be at least 2, the issue cycle plus waits
    localparam int CYC_WIDTH = $clog2(SLOT_CYCLES);
    localparam logic [OP_NUM_WIDTH-1:0] LAST_SLOT = OP_NUM_WIDTH'(NUM_OPERATORS - 1);
    localparam logic [CYC_WIDTH-1:0] LAST_WAIT = CYC_WIDTH'(SLOT_CYCLES - 2);

    seq_state_t state;
    logic [OP_NUM_WIDTH-1:0] slot_num;
    logic [CYC_WIDTH-1:0] wait_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SEQ_IDLE;
            slot_num <= '0;
            wait_cnt <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    slot_num <= '0;
                    if (sample_clk_en)
                        state <= SEQ_ISSUE;   // strobe only taken here
                end
                SEQ_ISSUE: begin
                    wait_cnt <= '0;
                    state <= SEQ_WAIT;
                end
                SEQ_WAIT: begin
                    if (wait_cnt != LAST_WAIT) begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end else if (slot_num == LAST_SLOT) begin
                        state <= SEQ_IDLE;    // sample finished
                    end else begin
                        slot_num <= slot_num + 1'b1;
                        state <= SEQ_ISSUE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // one issue in the first cycle of each slot
    assign issue.valid = (state == SEQ_ISSUE);
    assign issue.op_num = slot_num;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ops_done_pulse <= 1'b0;
        else
            ops_done_pulse <= operator_out.valid && (operator_out.op_num == LAST_SLOT);
    end

endmodule

`default_nettype wire

//--- source/operator_regs.sv
`timescale 1ns/1ps
`default_nettype none

module operator_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  opl_ops_pkg::reg_wr_t    reg_wr,
    input  opl_ops_pkg::op_tag_t    issue,
    output opl_ops_pkg::op_params_t params
);
    import opl_ops_pkg::*;

    localparam logic [2:0] MULT_PAGE = 3'h1;      // 0x20 window
    localparam logic [2:0] TL_PAGE = 3'h2;        // 0x40 window
    localparam logic [3:0] FNUM_LO_PAGE = 4'hA;
    localparam logic [3:0] KON_BLOCK_PAGE = 4'hB;
    localparam logic [3:0] CNT_PAGE = 4'hC;

    logic [MULT_WIDTH-1:0] mult_q [NUM_OPERATORS];
    logic [TL_WIDTH-1:0] tl_q [NUM_OPERATORS];
    logic [FNUM_WIDTH-1:0] fnum_q [NUM_CHANNELS];
    logic [BLOCK_WIDTH-1:0] block_q [NUM_CHANNELS];
    logic [NUM_CHANNELS-1:0] kon_q;
    logic [NUM_CHANNELS-1:0] cnt_q;

    logic [2:0] op_page;
    logic [3:0] ch_page;
    logic [NUM_OPERATORS-1:0] op_hit;
    logic [NUM_CHANNELS-1:0] ch_hit;
    logic [CHAN_WIDTH-1:0] rd_chan;

    assign op_page = reg_wr.address[REG_ADDR_WIDTH-1:OP_NUM_WIDTH];
    assign ch_page = reg_wr.address[REG_ADDR_WIDTH-1:CHAN_WIDTH];

    // gap offsets match no operator and fall through
    always_comb begin
        for (int i = 0; i < NUM_OPERATORS; i++) begin
            op_hit[i] = reg_wr.address[OP_NUM_WIDTH-1:0] == op_slot_addr(OP_NUM_WIDTH'(i));
        end
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            ch_hit[c] = reg_wr.address[CHAN_WIDTH-1:0] == CHAN_WIDTH'(c);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_OPERATORS; i++) begin
                mult_q[i] <= '0;
                tl_q[i] <= '0;
            end
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                fnum_q[c] <= '0;
                block_q[c] <= '0;
            end
            kon_q <= '0;
            cnt_q <= '0;
        end else if (reg_wr.valid) begin
            for (int i = 0; i < NUM_OPERATORS; i++) begin
                if (op_hit[i] && op_page == MULT_PAGE)
                    mult_q[i] <= reg_wr.data[MULT_WIDTH-1:0];
                if (op_hit[i] && op_page == TL_PAGE)
                    tl_q[i] <= reg_wr.data[TL_WIDTH-1:0];
            end
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                if (ch_hit[c]) begin
                    case (ch_page)
                        FNUM_LO_PAGE: fnum_q[c][7:0] <= reg_wr.data;
                        KON_BLOCK_PAGE: begin
                            kon_q[c] <= reg_wr.data[5];
                            block_q[c] <= reg_wr.data[4:2];
                            fnum_q[c][9:8] <= reg_wr.data[1:0];
                        end
                        CNT_PAGE: cnt_q[c] <= reg_wr.data[0];
                        default: ;
                    endcase
                end
            end
        end
    end

    assign rd_chan = op_channel(issue.op_num);

    // settings of the issued slot, ready in stage 1
    always_ff @(posedge clk) begin
        if (issue.valid) begin
            params.mult <= mult_q[issue.op_num];
            params.tl <= tl_q[issue.op_num];
            params.fnum <= fnum_q[rd_chan];
            params.block <= block_q[rd_chan];
            params.kon <= kon_q[rd_chan];
            params.cnt <= cnt_q[rd_chan];
        end
    end

endmodule

`default_nettype wire

//--- source/modulation_router.sv
`timescale 1ns/1ps
`default_nettype none

module modulation_router (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  opl_ops_pkg::op_tag_t                      issue,
    input  opl_ops_pkg::operator_out_t                operator_out,
    input  logic                                      cnt,
    output logic signed [opl_ops_pkg::OP_OUT_WIDTH-1:0] modulation
);
    import opl_ops_pkg::*;

    op_tag_t tag_p1;
    logic signed [OP_OUT_WIDTH-1:0] last_out;
    logic use_mod;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            tag_p1 <= '0;
        else
            tag_p1 <= issue;
    end

    // op k-3 finishes in the issue cycle of op k
    always_ff @(posedge clk) begin
        if (operator_out.valid)
            last_out <= operator_out.op_out;
    end

    assign use_mod = tag_p1.valid && op_is_carrier(tag_p1.op_num) && !cnt;  // FM only
    assign modulation = use_mod ? last_out : '0;

endmodule

`default_nettype wire

//--- operator/phase_gen.sv
`timescale 1ns/1ps
`default_nettype none

module phase_gen #(
    parameter int PHASE_WIDTH = opl_ops_pkg::PHASE_WIDTH
) (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  opl_ops_pkg::op_tag_t                          tag_in,
    input  opl_ops_pkg::op_params_t                       params,
    input  logic signed [opl_ops_pkg::OP_OUT_WIDTH-1:0]   modulation,
    output opl_ops_pkg::op_tag_t                          tag_out,
    output logic [opl_ops_pkg::PHASE_INDEX_WIDTH-1:0]     phase_index,
    output logic                                          kon_out,
    output logic [opl_ops_pkg::TL_WIDTH-1:0]              tl_out
);
    import opl_ops_pkg::*;

    localparam int FREQ_WIDTH = FNUM_WIDTH + (2 ** BLOCK_WIDTH) - 1;  // fnum at block 7
    localparam int STEP_WIDTH = FREQ_WIDTH + MULT_WIDTH;

    logic [PHASE_WIDTH-1:0] phase_acc [NUM_OPERATORS];
    op_tag_t tag_s1;
    op_tag_t tag_s2;
    op_tag_t tag_s3;
    logic [FREQ_WIDTH-1:0] freq;
    logic [STEP_WIDTH-1:0] step_full;
    logic [PHASE_WIDTH-1:0] step_s2;
    logic [PHASE_WIDTH-1:0] acc_next;
    logic kon_s2;
    logic kon_s3;
    logic [TL_WIDTH-1:0] tl_s2;
    logic [TL_WIDTH-1:0] tl_s3;
    logic [PHASE_INDEX_WIDTH-1:0] mod_s2;
    logic [PHASE_INDEX_WIDTH-1:0] mod_s3;
    logic [PHASE_INDEX_WIDTH-1:0] phase_s3;

    assign freq = FREQ_WIDTH'(params.fnum) << params.block;
    assign step_full = freq * params.mult;
    assign acc_next = kon_s2 ? phase_acc[tag_s2.op_num] + step_s2 : '0;  // key-off restarts

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_s1 <= '0;
            tag_s2 <= '0;
            tag_s3 <= '0;
            tag_out <= '0;
        end else begin
            tag_s1 <= tag_in;
            tag_s2 <= tag_s1;
            tag_s3 <= tag_s2;
            tag_out <= tag_s3;
        end
    end

    // slot is revisited only every sample, no read-write hazard
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_OPERATORS; i++) begin
                phase_acc[i] <= '0;
            end
        end else if (tag_s2.valid) begin
            phase_acc[tag_s2.op_num] <= acc_next;
        end
    end

    always_ff @(posedge clk) begin
        step_s2 <= step_full[PHASE_WIDTH-1:0];   // wraps mod 2^20
        kon_s2 <= params.kon;
        tl_s2 <= params.tl;
        mod_s2 <= modulation[PHASE_INDEX_WIDTH-1:0];
        phase_s3 <= acc_next[PHASE_WIDTH-1 -: PHASE_INDEX_WIDTH];
        kon_s3 <= kon_s2;
        tl_s3 <= tl_s2;
        mod_s3 <= mod_s2;
        phase_index <= phase_s3 + mod_s3;        // wraps mod 1024
        kon_out <= kon_s3;
        tl_out <= tl_s3;
    end

endmodule

`default_nettype wire

//--- operator/wave_shaper.sv
`timescale 1ns/1ps
`default_nettype none

module wave_shaper (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  opl_ops_pkg::op_tag_t                       tag_in,
    input  logic [opl_ops_pkg::PHASE_INDEX_WIDTH-1:0]  phase_index,
    input  logic                                       kon,
    input  logic [opl_ops_pkg::TL_WIDTH-1:0]           tl,
    output opl_ops_pkg::operator_out_t                 operator_out
);
    import opl_ops_pkg::*;

    localparam int SHIFT_WIDTH = TL_WIDTH - 3;   // tl/8

    op_tag_t tag_s5;
    logic signed [OP_OUT_WIDTH-1:0] saw;
    logic signed [OP_OUT_WIDTH-1:0] wave_s5;
    logic [SHIFT_WIDTH-1:0] shift_s5;

    // index read as a signed sawtooth
    assign saw = $signed(phase_index);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            tag_s5 <= '0;
        else
            tag_s5 <= tag_in;
    end

    always_ff @(posedge clk) begin
        wave_s5 <= kon ? saw : '0;               // silent on key-off
        shift_s5 <= tl[TL_WIDTH-1:3];
    end

    // attenuation, result visible in stage 6
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            operator_out <= '0;
        end else begin
            operator_out.valid <= tag_s5.valid;
            operator_out.op_num <= tag_s5.op_num;
            operator_out.op_out <= wave_s5 >>> shift_s5;
        end
    end

endmodule

`default_nettype wire

//--- source/opl_operators.sv
`timescale 1ns/1ps
`default_nettype none

module opl_operators #(
    parameter int NUM_OPERATORS = opl_ops_pkg::NUM_OPERATORS,
    parameter int SLOT_CYCLES = opl_ops_pkg::SLOT_CYCLES,
    parameter int PHASE_WIDTH = opl_ops_pkg::PHASE_WIDTH
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        sample_clk_en,
    input  opl_ops_pkg::reg_wr_t        reg_wr,
    output opl_ops_pkg::operator_out_t  operator_out,
    output logic                        ops_done_pulse
);
    import opl_ops_pkg::*;

    op_tag_t issue;
    op_params_t params;
    logic signed [OP_OUT_WIDTH-1:0] modulation;
    op_tag_t phase_tag;
    logic [PHASE_INDEX_WIDTH-1:0] phase_index;
    logic phase_kon;
    logic [TL_WIDTH-1:0] phase_tl;

    slot_sequencer #(
        .NUM_OPERATORS(NUM_OPERATORS),
        .SLOT_CYCLES(SLOT_CYCLES)
    ) slot_sequencer_inst (
        .clk,
        .rst_n,
        .sample_clk_en,
        .operator_out,
        .issue,
        .ops_done_pulse
    );

    operator_regs operator_regs_inst (
        .clk,
        .rst_n,
        .reg_wr,
        .issue,
        .params
    );

    modulation_router modulation_router_inst (
        .clk,
        .rst_n,
        .issue,
        .operator_out,
        .cnt(params.cnt),
        .modulation
    );

    phase_gen #(
        .PHASE_WIDTH(PHASE_WIDTH)
    ) phase_gen_inst (
        .clk,
        .rst_n,
        .tag_in(issue),
        .params,
        .modulation,
        .tag_out(phase_tag),
        .phase_index,
        .kon_out(phase_kon),
        .tl_out(phase_tl)
    );

    wave_shaper wave_shaper_inst (
        .clk,
        .rst_n,
        .tag_in(phase_tag),
        .phase_index,
        .kon(phase_kon),
        .tl(phase_tl),
        .operator_out
    );

endmodule

`default_nettype wire

//--- tests/opl_operators_checker.sv
`timescale 1ns/1ps
`default_nettype none

module opl_operators_checker (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       sample_clk_en,
    input opl_ops_pkg::operator_out_t operator_out,
    input logic                       ops_done_pulse
);
    import opl_ops_pkg::*;

    localparam logic [OP_NUM_WIDTH-1:0] LAST_OP = OP_NUM_WIDTH'(NUM_OPERATORS - 1);

    int error_count = 0;
    logic strobe_seen;
    logic [OP_NUM_WIDTH-1:0] next_op;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            strobe_seen <= 1'b0;
            next_op <= '0;
        end else begin
            if (operator_out.valid && operator_out.op_num == LAST_OP)
                strobe_seen <= 1'b0;          // next sample needs its own strobe
            if (sample_clk_en)
                strobe_seen <= 1'b1;
            if (operator_out.valid)
                next_op <= (operator_out.op_num == LAST_OP) ? '0 : operator_out.op_num + 1'b1;
        end
    end

    no_back_to_back: assert property (@(posedge clk) disable iff (!rst_n)
        operator_out.valid |=> !operator_out.valid)
        else begin
            $error("valid high in two consecutive cycles");
            error_count++;
        end

    op_order: assert property (@(posedge clk) disable iff (!rst_n)
        operator_out.valid |-> operator_out.op_num == next_op)
        else begin
            $error("op_num out of order");
            error_count++;
        end

    done_after_last: assert property (@(posedge clk) disable iff (!rst_n)
        ops_done_pulse == $past(operator_out.valid && operator_out.op_num == LAST_OP))
        else begin
            $error("ops_done_pulse not one cycle after the last result");
            error_count++;
        end

    valid_needs_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        operator_out.valid |-> strobe_seen)
        else begin
            $error("result without any sample strobe");
            error_count++;
        end

endmodule

bind opl_operators opl_operators_checker protocol_checker (
    .clk(clk),
    .rst_n(rst_n),
    .sample_clk_en(sample_clk_en),
    .operator_out(operator_out),
    .ops_done_pulse(ops_done_pulse)
);

`default_nettype wire

//--- tests/opl_operators_tb.sv
`timescale 1ns/1ps
`default_nettype none

module opl_operators_tb;
    import opl_ops_pkg::*;

    localparam int NUM_SAMPLES = 22;   // samples run over all tests
    localparam int CLK_PERIOD = 40;

    logic clk = 1'b0;
    logic rst_n;
    logic sample_clk_en;
    reg_wr_t reg_wr;
    operator_out_t operator_out;
    logic ops_done_pulse;

    logic [31:0] lfsr = 32'hcc3d5051;
    logic [3:0] mult_r [NUM_OPERATORS];    // register shadow
    logic [5:0] tl_r [NUM_OPERATORS];
    logic [9:0] fnum_r [NUM_CHANNELS];
    logic [2:0] block_r [NUM_CHANNELS];
    logic kon_r [NUM_CHANNELS];
    logic cnt_r [NUM_CHANNELS];
    int acc [NUM_OPERATORS];               // model phase accumulators
    int exp_out [NUM_OPERATORS];
    int cycle = 0;
    int strobe_cycle = 0;
    int last_valid = 0;
    int actual;
    int results = 0;
    int done_count = 0;
    int checks = 0;
    int errors = 0;
    int total_errors;
    int tests_run = 0;
    int test_checks = 0;
    int test_errors = 0;
    string test_name = "reset";

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    opl_operators #(
        .NUM_OPERATORS(NUM_OPERATORS),
        .SLOT_CYCLES(SLOT_CYCLES),
        .PHASE_WIDTH(PHASE_WIDTH)
    ) opl_operators_inst (
        .clk(clk),
        .rst_n(rst_n),
        .sample_clk_en(sample_clk_en),
        .reg_wr(reg_wr),
        .operator_out(operator_out),
        .ops_done_pulse(ops_done_pulse)
    );

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
        return value;
    endfunction

    // register offset back to operator or -1 for gaps
    function automatic int offset_to_op(input int offset);
        if (offset < 6)
            return offset;
        if (offset >= 8 && offset < 14)
            return offset - 2;
        if (offset >= 16 && offset < 22)
            return offset - 4;
        return -1;
    endfunction

    task automatic report_mismatch(input string what, input int expected, input int got);
        errors++;
        $display("** Error [%s] %s: expected %0d, actual %0d", test_name, what, expected, got);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("[%s] %s", test_name, what);
    endtask

    task automatic open_test(input string name);
        test_name = name;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic close_test();
        tests_run++;
        $display("test %s: %0d checks, %0d errors", test_name, checks - test_checks,
                 errors - test_errors);
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        int op;
        int ch;
        op = offset_to_op(int'(addr[4:0]));
        ch = int'(addr[3:0]);
        @(posedge clk);
        #1;
        reg_wr.valid = 1'b1;
        reg_wr.address = addr;
        reg_wr.data = data;
        if (addr[7:5] == 3'h1 && op >= 0)
            mult_r[op] = data[3:0];
        else if (addr[7:5] == 3'h2 && op >= 0)
            tl_r[op] = data[5:0];
        else if (ch < NUM_CHANNELS) begin
            case (addr[7:4])
                4'ha: fnum_r[ch][7:0] = data;
                4'hb: begin
                    kon_r[ch] = data[5];
                    block_r[ch] = data[4:2];
                    fnum_r[ch][9:8] = data[1:0];
                end
                4'hc: cnt_r[ch] = data[0];
                default: ;
            endcase
        end
    endtask

    task automatic set_random_voices();
        logic [9:0] fnum;
        logic [2:0] block;
        int off;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            fnum = 10'(random_bits(10));
            block = 3'(random_bits(3));
            write_reg(8'ha0 + 8'(c), fnum[7:0]);
            write_reg(8'hb0 + 8'(c), {2'b00, 1'b1, block, fnum[9:8]});
            write_reg(8'hc0 + 8'(c), 8'h01);   // additive
        end
        for (int k = 0; k < NUM_OPERATORS; k++) begin
            off = k + (k / 6) * 2;
            write_reg(8'h20 + 8'(off), 8'(random_bits(4)));
            write_reg(8'h40 + 8'(off), 8'(random_bits(6)));
        end
    endtask

    // one sample of the operator rule in issue order
    task automatic predict_sample();
        int ch;
        int step;
        int modv;
        int idx;
        for (int k = 0; k < NUM_OPERATORS; k++) begin
            ch = (k / 6) * 3 + k % 3;
            if (kon_r[ch]) begin
                step = (int'(fnum_r[ch]) << block_r[ch]) * int'(mult_r[k]);
                acc[k] = (acc[k] + step) & 32'h000fffff;
                modv = (k % 6 >= 3 && !cnt_r[ch]) ? exp_out[k - 3] : 0;
                idx = ((acc[k] >> 10) + modv) & 1023;
                if (idx >= 512)
                    idx = idx - 1024;            // signed 10-bit read
                exp_out[k] = idx >>> (tl_r[k] / 8);
            end else begin
                acc[k] = 0;
                exp_out[k] = 0;
            end
        end
    endtask

    task automatic run_sample(input bit busy_strobe);
        int waited;
        predict_sample();
        results = 0;
        @(posedge clk);
        #1;
        reg_wr = '0;
        sample_clk_en = 1'b1;
        strobe_cycle = cycle;
        @(posedge clk);
        #1;
        sample_clk_en = 1'b0;
        waited = 0;
        while (!ops_done_pulse && waited < 60) begin
            @(posedge clk);
            #1;
            waited++;
            sample_clk_en = busy_strobe && (waited == 10);   // ignored mid-sample
        end
        assert (ops_done_pulse)
            else report_failure("no ops_done_pulse within 60 cycles of the strobe");
        assert (results == NUM_OPERATORS)
            else report_mismatch("results per sample", NUM_OPERATORS, results);
    endtask

    always @(negedge clk) begin
        if (rst_n && operator_out.valid) begin
            actual = $signed(operator_out.op_out);
            checks++;
            assert (actual == exp_out[operator_out.op_num])
                else report_mismatch($sformatf("op %0d output", operator_out.op_num),
                                     exp_out[operator_out.op_num], actual);
            if (operator_out.op_num == 0) begin
                assert (cycle - strobe_cycle == 7)
                    else report_mismatch("cycles from strobe to op 0", 7, cycle - strobe_cycle);
            end else begin
                assert (cycle - last_valid == SLOT_CYCLES)
                    else report_mismatch("cycles between results", SLOT_CYCLES,
                                         cycle - last_valid);
            end
            last_valid = cycle;
            results++;
        end
        if (rst_n && ops_done_pulse)
            done_count++;
    end

    initial begin
        #((NUM_SAMPLES * 45 + 200) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        sample_clk_en = 1'b0;
        reg_wr = '0;
        for (int k = 0; k < NUM_OPERATORS; k++) begin
            mult_r[k] = '0;
            tl_r[k] = '0;
            acc[k] = 0;
            exp_out[k] = 0;
        end
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            fnum_r[c] = '0;
            block_r[c] = '0;
            kon_r[c] = 1'b0;
            cnt_r[c] = 1'b0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        open_test("after_reset");
        repeat (10) @(posedge clk);
        assert (results == 0 && done_count == 0)
            else report_failure("valid or ops_done_pulse seen before the first strobe");
        run_sample(1'b0);
        close_test();

        open_test("key_off_silence");
        repeat (3) run_sample(1'b0);
        close_test();

        open_test("additive");
        set_random_voices();
        repeat (8) run_sample(1'b0);
        close_test();

        open_test("fm_modulation");
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            write_reg(8'hc0 + 8'(c), 8'h00);
        end
        repeat (4) run_sample(1'b0);
        close_test();

        open_test("register_decode");
        write_reg(8'h26, 8'(random_bits(8)));   // gap offsets
        write_reg(8'h27, 8'(random_bits(8)));
        write_reg(8'h2e, 8'(random_bits(8)));
        write_reg(8'h2f, 8'(random_bits(8)));
        run_sample(1'b0);
        write_reg(8'hc3, 8'h01);                // keep op 9 off op 6
        write_reg(8'h28, {4'h0, mult_r[6] + 4'h1});
        run_sample(1'b0);
        write_reg(8'hb4, {2'b00, 1'b0, block_r[4], fnum_r[4][9:8]});
        run_sample(1'b0);
        write_reg(8'hb4, {2'b00, 1'b1, block_r[4], fnum_r[4][9:8]});
        run_sample(1'b0);
        close_test();

        open_test("strobe_while_busy");
        run_sample(1'b1);
        repeat (20) @(posedge clk);
        assert (results == NUM_OPERATORS)
            else report_mismatch("results after a busy strobe", NUM_OPERATORS, results);
        run_sample(1'b0);
        close_test();

        total_errors = errors + opl_operators_inst.protocol_checker.error_count;
        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, total_errors);
        if (total_errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
common/opl_ops_pkg.sv
source/slot_sequencer.sv
source/operator_regs.sv
source/modulation_router.sv
operator/phase_gen.sv
operator/wave_shaper.sv
source/opl_operators.sv
tests/opl_operators_checker.sv
tests/opl_operators_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and search the log for failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module opl_operators_tb -o opl_sim \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/opl_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    || { cat sim.log; echo "simulation exited with an error"; exit 1; }

cat sim.log
grep -q "TEST FAILED" sim.log && { echo "failure found in sim.log"; exit 1; }
exit 0
